// ==== src/stopwatch_pkg.sv ====
package stopwatch_pkg;

    // one BCD digit
    localparam int DIGIT_W = 4;

    // HH:MM:SS.cc on an eight-digit display
    localparam int NUM_DIGITS = 8;

    // board defaults for a 100 MHz clock
    // 10 ms per hundredth
    localparam int TICK_DIV_DEFAULT = 1_000_000;
    // 1 ms per scan position
    localparam int SCAN_DIV_DEFAULT = 100_000;
    // about 10 ms of stable level per button change
    localparam int DEBOUNCE_DEFAULT = 1_000_000;

    // run/stop/clear controller states
    typedef enum logic [1:0] {
        st_idle,
        st_running,
        st_stopped
    } ctrl_state_t;

    // all segments off in active-low form
    localparam logic [6:0] SEG_BLANK = 7'b111_1111;

endpackage

// ==== src/time_digits_if.sv ====
`timescale 1ns/1ps

interface time_digits_if;
    import stopwatch_pkg::*;

    // hundredths and tenths
    logic [DIGIT_W-1:0] d0;
    logic [DIGIT_W-1:0] d1;
    // seconds units and tens up to 5
    logic [DIGIT_W-1:0] d2;
    logic [DIGIT_W-1:0] d3;
    // minutes units and tens up to 5
    logic [DIGIT_W-1:0] d4;
    logic [DIGIT_W-1:0] d5;
    // hours 00 to 99
    logic [DIGIT_W-1:0] d6;
    logic [DIGIT_W-1:0] d7;

    modport src (output d0, d1, d2, d3, d4, d5, d6, d7);
    modport snk (input d0, d1, d2, d3, d4, d5, d6, d7);

endinterface

// ==== src/button_ctrl_fsm.sv ====
`timescale 1ns/1ps

module button_ctrl_fsm #(
    parameter int DEBOUNCE = stopwatch_pkg::DEBOUNCE_DEFAULT
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        btn_run,
    input  logic                        btn_clr,
    output logic                        run,
    output logic                        clr,
    output stopwatch_pkg::ctrl_state_t  state
);
    import stopwatch_pkg::*;

    localparam int CNT_W = $clog2(DEBOUNCE + 1);
    localparam int B_RUN = 0;
    localparam int B_CLR = 1;

    logic [1:0]       btn_in;
    logic [1:0]       sync_1;
    logic [1:0]       sync_2;
    logic [1:0]       filt;
    logic [1:0]       press;
    logic [CNT_W-1:0] stable_cnt [2];
    ctrl_state_t      state_nxt;

    assign btn_in = {btn_clr, btn_run};

    // a press is the accepted rising edge of the filtered level
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            press[i] = sync_2[i] && !filt[i] && (stable_cnt[i] == CNT_W'(DEBOUNCE - 1));
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_1 <= '0;
            sync_2 <= '0;
            filt   <= '0;
            for (int i = 0; i < 2; i++) begin
                stable_cnt[i] <= '0;
            end
        end else begin
            sync_1 <= btn_in;
            sync_2 <= sync_1;
            for (int i = 0; i < 2; i++) begin
                // count only while the synced level differs from the filtered one
                if (sync_2[i] == filt[i]) begin
                    stable_cnt[i] <= '0;
                end else if (stable_cnt[i] == CNT_W'(DEBOUNCE - 1)) begin
                    stable_cnt[i] <= '0;
                    filt[i]       <= sync_2[i];
                end else begin
                    stable_cnt[i] <= stable_cnt[i] + 1'b1;
                end
            end
        end
    end

    // clear presses while running fall through unchanged
    always_comb begin
        state_nxt = state;
        case (state)
            st_idle:    if (press[B_RUN]) state_nxt = st_running;
            st_running: if (press[B_RUN]) state_nxt = st_stopped;
            st_stopped: begin
                if (press[B_RUN]) begin
                    state_nxt = st_running;
                end else if (press[B_CLR]) begin
                    state_nxt = st_idle;
                end
            end
            default:    state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
            clr   <= 1'b0;
        end else begin
            state <= state_nxt;
            clr   <= (state == st_stopped) && (state_nxt == st_idle);
        end
    end

    assign run = (state == st_running);

endmodule

// ==== src/tick_timer.sv ====
`timescale 1ns/1ps

module tick_timer #(
    parameter int TICK_DIV = stopwatch_pkg::TICK_DIV_DEFAULT,
    parameter int SCAN_DIV = stopwatch_pkg::SCAN_DIV_DEFAULT
) (
    input  logic clk,
    input  logic arst_n,
    input  logic run,
    output logic tick_cs,
    output logic scan_step
);

    localparam int TICK_W = $clog2(TICK_DIV + 1);
    localparam int SCAN_W = $clog2(SCAN_DIV + 1);

    logic [TICK_W-1:0] tick_cnt;
    logic [SCAN_W-1:0] scan_cnt;

    // hundredths divider holds its count while stopped
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tick_cnt <= '0;
        end else if (run) begin
            if (tick_cnt == '0) begin
                tick_cnt <= TICK_W'(TICK_DIV - 1);
            end else begin
                tick_cnt <= tick_cnt - 1'b1;
            end
        end
    end

    // scan divider never stops
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scan_cnt <= '0;
        end else if (scan_cnt == '0) begin
            scan_cnt <= SCAN_W'(SCAN_DIV - 1);
        end else begin
            scan_cnt <= scan_cnt - 1'b1;
        end
    end

    assign tick_cs   = run && (tick_cnt == '0);
    assign scan_step = (scan_cnt == '0);

endmodule

// ==== src/time_counter_chain.sv ====
`timescale 1ns/1ps

module time_counter_chain (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          tick_cs,
    input  logic          clr,
    time_digits_if.src    digits
);
    import stopwatch_pkg::*;

    logic [DIGIT_W-1:0] q [NUM_DIGITS];
    logic [NUM_DIGITS-1:0] en;
    logic [NUM_DIGITS-1:0] wrap;

    // seconds tens and minutes tens are modulo 6
    function automatic logic [DIGIT_W-1:0] digit_max(input int idx);
        if (idx == 3 || idx == 5) begin
            return DIGIT_W'(5);
        end
        return DIGIT_W'(9);
    endfunction

    // carries ripple combinationally from the tick
    always_comb begin
        en[0]   = tick_cs;
        wrap[0] = en[0] && (q[0] == digit_max(0));
        for (int i = 1; i < NUM_DIGITS; i++) begin
            en[i]   = wrap[i-1];
            wrap[i] = en[i] && (q[i] == digit_max(i));
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_DIGITS; i++) begin
                q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_DIGITS; i++) begin
                // clear wins over a tick in the same cycle
                if (clr || wrap[i]) begin
                    q[i] <= '0;
                end else if (en[i]) begin
                    q[i] <= q[i] + 1'b1;
                end
            end
        end
    end

    assign digits.d0 = q[0];
    assign digits.d1 = q[1];
    assign digits.d2 = q[2];
    assign digits.d3 = q[3];
    assign digits.d4 = q[4];
    assign digits.d5 = q[5];
    assign digits.d6 = q[6];
    assign digits.d7 = q[7];

endmodule

// ==== src/display_scan.sv ====
`timescale 1ns/1ps

module display_scan (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                scan_step,
    time_digits_if.snk                          digits,
    output logic [6:0]                          seg,
    output logic [stopwatch_pkg::NUM_DIGITS-1:0] an
);
    import stopwatch_pkg::*;

    localparam int IDX_W = $clog2(NUM_DIGITS);

    logic [IDX_W-1:0]   idx;
    logic [DIGIT_W-1:0] cur_digit;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            idx <= '0;
        end else if (scan_step) begin
            idx <= idx + 1'b1;
        end
    end

    // one anode low at a time
    always_comb begin
        an      = '1;
        an[idx] = 1'b0;
    end

    always_comb begin
        case (idx)
            3'd0:    cur_digit = digits.d0;
            3'd1:    cur_digit = digits.d1;
            3'd2:    cur_digit = digits.d2;
            3'd3:    cur_digit = digits.d3;
            3'd4:    cur_digit = digits.d4;
            3'd5:    cur_digit = digits.d5;
            3'd6:    cur_digit = digits.d6;
            default: cur_digit = digits.d7;
        endcase
    end

    // active-low patterns with bit 6 as g and bit 0 as a
    always_comb begin
        case (cur_digit)
            4'd0:    seg = 7'b100_0000;
            4'd1:    seg = 7'b111_1001;
            4'd2:    seg = 7'b010_0100;
            4'd3:    seg = 7'b011_0000;
            4'd4:    seg = 7'b001_1001;
            4'd5:    seg = 7'b001_0010;
            4'd6:    seg = 7'b000_0010;
            4'd7:    seg = 7'b111_1000;
            4'd8:    seg = 7'b000_0000;
            4'd9:    seg = 7'b001_0000;
            // not a BCD value
            default: seg = SEG_BLANK;
        endcase
    end

endmodule

// ==== src/stopwatch_top.sv ====
`timescale 1ns/1ps

module stopwatch_top #(
    parameter int TICK_DIV = stopwatch_pkg::TICK_DIV_DEFAULT,
    parameter int SCAN_DIV = stopwatch_pkg::SCAN_DIV_DEFAULT,
    parameter int DEBOUNCE = stopwatch_pkg::DEBOUNCE_DEFAULT
) (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                btn_run,
    input  logic                                btn_clr,
    output logic [6:0]                          seg,
    output logic [stopwatch_pkg::NUM_DIGITS-1:0] an
);
    import stopwatch_pkg::*;

    logic        run;
    logic        clr;
    logic        tick_cs;
    logic        scan_step;
    // controller state for waveforms
    ctrl_state_t state;

    time_digits_if u_digits ();

    button_ctrl_fsm #(.DEBOUNCE(DEBOUNCE)) u_ctrl (
        .clk(clk), .arst_n(arst_n),
        .btn_run(btn_run), .btn_clr(btn_clr),
        .run(run), .clr(clr), .state(state)
    );

    tick_timer #(.TICK_DIV(TICK_DIV), .SCAN_DIV(SCAN_DIV)) u_timer (
        .clk(clk), .arst_n(arst_n), .run(run),
        .tick_cs(tick_cs), .scan_step(scan_step)
    );

    time_counter_chain u_counters (
        .clk(clk), .arst_n(arst_n),
        .tick_cs(tick_cs), .clr(clr), .digits(u_digits.src)
    );

    display_scan u_display (
        .clk(clk), .arst_n(arst_n), .scan_step(scan_step),
        .digits(u_digits.snk), .seg(seg), .an(an)
    );

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS    = 8.0,
    parameter int  RESET_CYCLES = 10
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // reset released on a rising edge after the hold time
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

// ==== tb/tb_stopwatch.sv ====
`timescale 1ns/1ps

module tb_stopwatch;

    localparam int TICK_DIV = 4;
    localparam int SCAN_DIV = 2;
    localparam int DEBOUNCE = 3;
    // carry test spans a little over one minute of hundredths
    localparam int LONG_RUN = 6_100 * TICK_DIV;
    // all tests together plus a fifth of margin
    localparam int CYCLE_LIMIT = (LONG_RUN + 2_000) * 12 / 10;

    logic        clk;
    logic        arst_n;
    logic        btn_run;
    logic        btn_clr;
    logic [6:0]  seg;
    logic [7:0]  an;
    logic [6:0]  seg_table [10] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19,
                                    7'h12, 7'h02, 7'h78, 7'h00, 7'h10};
    logic [3:0]  cur [8];
    logic [7:0]  seen = '0;
    logic [2:0]  last_pos = '0;
    logic [31:0] shown = '1;
    int          sweeps = 0;
    int          mon_fails = 0;
    int          cycles = 0;
    int          run_cycles = 0;
    int          run_base = 0;
    int          model_state = 0;
    logic        model_running;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    integer      seed;

    tb_clock_gen u_clk (.clk(clk), .arst_n(arst_n));

    stopwatch_top #(.TICK_DIV(TICK_DIV), .SCAN_DIV(SCAN_DIV), .DEBOUNCE(DEBOUNCE)) DUT (
        .clk(clk), .arst_n(arst_n), .btn_run(btn_run), .btn_clr(btn_clr),
        .seg(seg), .an(an)
    );

    function automatic logic [3:0] decode_seg(input logic [6:0] s);
        for (int i = 0; i < 10; i++) begin
            if (seg_table[i] == s) begin
                return 4'(i);
            end
        end
        return 4'hf;
    endfunction

    // packed BCD d7..d0 to hundredths
    function automatic int to_hund(input logic [31:0] b);
        int h;
        int w [8] = '{1, 10, 100, 1000, 6000, 60000, 360000, 3600000};
        h = 0;
        for (int i = 0; i < 8; i++) begin
            h = h + w[i] * int'(b[4*i +: 4]);
        end
        return h;
    endfunction

    function automatic logic [31:0] to_bcd(input int h);
        int secs;
        int mins;
        int hrs;
        secs = (h / 100) % 60;
        mins = (h / 6000) % 60;
        hrs  = (h / 360000) % 100;
        return {4'(hrs / 10), 4'(hrs % 10), 4'(mins / 10), 4'(mins % 10),
                4'(secs / 10), 4'(secs % 10), 4'((h / 10) % 10), 4'(h % 10)};
    endfunction

    function automatic int pick_hold(input bit long_press);
        if (long_press) begin
            return DEBOUNCE + int'($unsigned($random(seed)) % 4);
        end
        return 1 + int'($unsigned($random(seed)) % 2);
    endfunction

    // display monitor samples on the falling edge
    always @(negedge clk) begin
        logic [2:0] pos;
        logic [3:0] dig;
        if (arst_n) begin
            pos = '0;
            for (int i = 0; i < 8; i++) begin
                if (!an[i]) begin
                    pos = 3'(i);
                end
            end
            assert ($countones(~an) == 1 && (pos == last_pos || pos == last_pos + 3'd1))
            else begin
                mon_fails++;
                $display("anode pattern %b is not one active digit in scan order", an);
            end
            dig = decode_seg(seg);
            assert (dig != 4'hf) else begin
                mon_fails++;
                $display("ERROR seg: expected a digit pattern, got 0x%h", seg);
            end
            // tens of seconds and minutes stop at 5
            assert (!((pos == 3'd3 || pos == 3'd5) && dig > 4'd5 && dig != 4'hf)) else begin
                mon_fails++;
                $display("ERROR d%0d: expected at most 0x5, got 0x%h", pos, dig);
            end
            if ($countones(~an) == 1) begin
                cur[pos]  = dig;
                seen[pos] = 1'b1;
                last_pos  = pos;
                if (pos == 3'd7 && seen == 8'hff) begin
                    shown = {cur[7], cur[6], cur[5], cur[4], cur[3], cur[2], cur[1], cur[0]};
                    seen  = '0;
                    sweeps++;
                end
            end
        end
    end

    // cycle limit and the model's running time
    always @(posedge clk) begin
        cycles++;
        if (model_running) begin
            run_cycles++;
        end
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic wait_sweeps(input int n);
        int target;
        target = sweeps + n;
        while (sweeps < target) begin
            @(posedge clk);
        end
    endtask

    task automatic press(input bit is_run, input int hold);
        @(posedge clk);
        if (is_run) begin
            btn_run <= 1'b1;
        end else begin
            btn_clr <= 1'b1;
        end
        // start and stop share the same latency, so counting from here is exact
        if (hold >= DEBOUNCE) begin
            if (is_run) begin
                model_state = (model_state == 1) ? 2 : 1;
                model_running <= (model_state == 1);
            end else if (model_state == 2) begin
                model_state = 0;
                run_base = run_cycles;
            end
        end
        repeat (hold) @(posedge clk);
        btn_run <= 1'b0;
        btn_clr <= 1'b0;
        repeat (2 * DEBOUNCE + 4) @(posedge clk);
    endtask

    task automatic expect_shown(input logic [31:0] exp, input string what);
        assert (shown == exp) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
            $display("ERROR shown (%s): expected 0x%08h, got 0x%08h", what, exp, shown);
        end
    endtask

    // stopped display against the model within one hundredth
    task automatic check_time(input string what);
        int exp_h;
        int got_h;
        wait_sweeps(2);
        exp_h = (run_cycles - run_base) / TICK_DIV;
        got_h = to_hund(shown);
        assert (got_h >= exp_h - 1 && got_h <= exp_h + 1) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
            $display("ERROR shown (%s): expected 0x%08h, got 0x%08h",
                     what, to_bcd(exp_h), shown);
        end
    endtask

    task automatic end_test(input string name, input int fails_before);
        if (fail_cnt + mon_fails == fails_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d failure(s)", name, fail_cnt + mon_fails - fails_before);
        end
    endtask

    initial begin
        int          f0;
        logic [31:0] frozen;
        seed = 32'h62ac_c283;
        btn_run <= 1'b0;
        btn_clr <= 1'b0;
        model_running <= 1'b0;
        wait (arst_n);

        f0 = 0;
        wait_sweeps(2);
        expect_shown(32'h0, "after reset");
        end_test("test 1 reset and scan", f0);

        f0 = fail_cnt + mon_fails;
        repeat (4) press(1'b1, pick_hold(1'b0));
        wait_sweeps(2);
        expect_shown(32'h0, "short presses");
        press(1'b1, pick_hold(1'b1));
        repeat (200 + int'($unsigned($random(seed)) % 100)) @(posedge clk);
        assert (shown != 32'h0) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
            $display("display did not advance while running");
        end
        press(1'b1, pick_hold(1'b1));
        check_time("first stop");
        end_test("test 2 debounce and start", f0);

        f0 = fail_cnt + mon_fails;
        frozen = shown;
        wait_sweeps(4);
        expect_shown(frozen, "frozen");
        press(1'b1, pick_hold(1'b1));
        repeat (200) @(posedge clk);
        press(1'b1, pick_hold(1'b1));
        check_time("resume");
        end_test("test 3 stop and resume", f0);

        f0 = fail_cnt + mon_fails;
        press(1'b1, pick_hold(1'b1));
        repeat (100) @(posedge clk);
        press(1'b0, pick_hold(1'b1));
        repeat (100) @(posedge clk);
        press(1'b1, pick_hold(1'b1));
        check_time("clear while running");
        press(1'b0, pick_hold(1'b1));
        wait_sweeps(2);
        expect_shown(32'h0, "clear while stopped");
        press(1'b1, pick_hold(1'b1));
        repeat (80) @(posedge clk);
        press(1'b1, pick_hold(1'b1));
        check_time("restart after clear");
        press(1'b0, pick_hold(1'b1));
        end_test("test 4 clear", f0);

        f0 = fail_cnt + mon_fails;
        press(1'b1, pick_hold(1'b1));
        repeat (LONG_RUN) @(posedge clk);
        press(1'b1, pick_hold(1'b1));
        check_time("minute carry");
        assert (shown[19:16] == 4'h1) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
            $display("ERROR d4: expected 0x1, got 0x%h", shown[19:16]);
        end
        end_test("test 5 minute carry", f0);

        $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt + mon_fails);
        if (fail_cnt + mon_fails == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== src.f ====
src/stopwatch_pkg.sv
src/time_digits_if.sv
src/button_ctrl_fsm.sv
src/tick_timer.sv
src/time_counter_chain.sv
src/display_scan.sv
src/stopwatch_top.sv
tb/tb_clock_gen.sv
tb/tb_stopwatch.sv

// ==== Makefile ====
TOP := tb_stopwatch

.PHONY: all build lint clean

all: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "RESULT: PASS" sim.log

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f src.f

lint:
	verilator --lint-only --timing -Wall --top-module stopwatch_top -f src.f

clean:
	rm -rf obj_dir sim.log
